//--- run_sim.sh
#!/bin/sh
# Build and run the TPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --top-module tpu_tb \
  -f tritone_tpu.f -Mdir "$build_dir" -o tpu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/tpu_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "^=== PASS ===$" "$log"; then
  exit 0
fi
echo "Pass message not found in $log"
exit 1

//--- source/layer_sequencer.sv
`default_nettype none

module layer_sequencer (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,        // One-cycle launch pulse
  input  tpu_pkg::dim_t     rows,
  input  tpu_pkg::dim_t     k,
  output logic              busy,
  output logic              done,         // Held until next start
  // Issue stage reads
  output logic              wgt_rd_en,
  output tpu_pkg::buf_idx_t wgt_rd_idx,
  output logic              act_rd_en,
  output tpu_pkg::buf_idx_t act_rd_idx,
  // MAC stage
  output logic              acc_en,
  output logic              acc_load,
  // Write stage
  output logic              out_wr_en,
  output tpu_pkg::buf_idx_t out_wr_idx
);
  import tpu_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_run,     // One issue per cycle
    st_drain    // Two cycles to flush MAC and write stages
  } state_t;

  state_t   state;
  dim_t     rows_q;
  dim_t     k_q;
  dim_t     row_cnt;
  dim_t     k_cnt;
  buf_idx_t act_ptr;      // Running r*K+k
  logic     drain_cnt;

  logic     iss_valid;
  logic     iss_first;
  logic     iss_last;

  logic     s1_valid;
  logic     s1_first;
  logic     s1_last;
  buf_idx_t s1_row;
  logic     s2_valid;
  buf_idx_t s2_row;

  // ====================
  // Issue stage
  // ====================
  assign iss_valid = (state == st_run);
  assign iss_first = (k_cnt == '0);
  assign iss_last  = (k_cnt == k_q - 16'd1);

  assign wgt_rd_en  = iss_valid;
  assign wgt_rd_idx = buf_idx_t'(k_cnt);
  assign act_rd_en  = iss_valid;
  assign act_rd_idx = act_ptr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      busy      <= 1'b0;
      done      <= 1'b0;
      rows_q    <= '0;
      k_q       <= '0;
      row_cnt   <= '0;
      k_cnt     <= '0;
      act_ptr   <= '0;
      drain_cnt <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            rows_q    <= rows;    // Shape frozen for the run
            k_q       <= k;
            row_cnt   <= '0;
            k_cnt     <= '0;
            act_ptr   <= '0;
            drain_cnt <= 1'b0;
            busy      <= 1'b1;
            done      <= 1'b0;
            // Empty layer goes straight to the drain
            state     <= (rows == '0 || k == '0) ? st_drain : st_run;
          end
        end
        st_run: begin
          act_ptr <= act_ptr + 1'b1;
          if (iss_last) begin
            k_cnt   <= '0;
            row_cnt <= row_cnt + 16'd1;
            if (row_cnt == rows_q - 16'd1) begin
              state <= st_drain;
            end
          end else begin
            k_cnt <= k_cnt + 16'd1;
          end
        end
        st_drain: begin
          drain_cnt <= 1'b1;
          if (drain_cnt) begin
            state <= st_idle;
            busy  <= 1'b0;   // Falls with done rising
            done  <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ====================
  // MAC and write stages
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= iss_valid;
      s2_valid <= s1_valid & s1_last;   // Row complete after last accumulate
    end
  end

  always_ff @(posedge clk) begin
    s1_first <= iss_first;
    s1_last  <= iss_last;
    s1_row   <= buf_idx_t'(row_cnt);
    s2_row   <= s1_row;
  end

  assign acc_en     = s1_valid;
  assign acc_load   = s1_valid & s1_first;
  assign out_wr_en  = s2_valid;
  assign out_wr_idx = s2_row;

  // Register block only pulses start between runs
  a_no_restart: assert property (
    @(posedge clk) disable iff (!rst_n) start |-> !busy
  ) else $error("start while busy");

endmodule

`default_nettype wire

//--- source/ternary_mac_row.sv
`default_nettype none

module ternary_mac_row (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               acc_en,      // Accumulate this cycle
  input  logic               acc_load,    // First k of a row, start from zero
  input  tpu_pkg::wgt_word_t weights,     // Trit per lane
  input  tpu_pkg::act_t      act,         // Broadcast to all lanes
  output tpu_pkg::acc_vec_t  sums,
  output tpu_pkg::skip_cnt_t skip_count   // Zero trits this cycle
);
  import tpu_pkg::*;

  localparam int lanes = $bits(acc_vec_t) / $bits(acc_t);

  acc_t     act_ext;
  acc_t     base;
  acc_vec_t next_sums;

  assign act_ext = acc_t'(act);   // Sign-extend to accumulator width

  // ====================
  // Lane update
  // ====================
  always_comb begin
    next_sums  = sums;
    skip_count = '0;
    for (int i = 0; i < lanes; i++) begin
      base = acc_load ? '0 : sums[i];
      case (weights[i])
        trit_pos: next_sums[i] = base + act_ext;
        trit_neg: next_sums[i] = base - act_ext;
        default: begin
          // Zero or reserved code, lane does no work
          next_sums[i] = base;
          if (acc_en) begin
            skip_count = skip_count + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (acc_en) begin
      sums <= next_sums;
    end
  end

  // Sequencer only asserts load inside a MAC-stage slot
  a_load_in_slot: assert property (
    @(posedge clk) disable iff (!rst_n) acc_load |-> acc_en
  ) else $error("acc_load without acc_en");

endmodule

`default_nettype wire

//--- source/tpu_buffer.sv
`default_nettype none

module tpu_buffer #(
  parameter type entry_t = logic [7:0],   // Payload of one entry
  parameter int  depth   = 64
) (
  input  logic              clk,
  // Write port
  input  logic              wr_en,
  input  tpu_pkg::buf_idx_t wr_idx,
  input  entry_t            wr_data,
  // Read port, one cycle latency
  input  logic              rd_en,
  input  tpu_pkg::buf_idx_t rd_idx,
  output entry_t            rd_data
);

  entry_t mem [depth];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_idx] <= wr_data;
    end
    // Read data holds between reads
    if (rd_en) begin
      rd_data <= mem[rd_idx];
    end
  end

endmodule

`default_nettype wire

//--- source/tpu_params.svh
`ifndef TPU_PARAMS_SVH
`define TPU_PARAMS_SVH

// ====================
// Array shape and widths
// ====================
`define TPU_LANES     4           // MAC lanes in the row
`define TPU_ACT_BITS  8           // Signed activation
`define TPU_ACC_BITS  20          // Signed accumulator per lane
`define TPU_WGT_DEPTH 64
`define TPU_ACT_DEPTH 64
`define TPU_OUT_DEPTH 64          // One entry per output row
`define TPU_DATA_BITS 32          // CPU data bus
`define TPU_ADDR_BITS 12          // CPU byte address
`define TPU_VERSION   16'h0002    // ARRAY_INFO[31:16]

// ====================
// Register map
// ====================
`define TPU_REG_CTRL       8'h00
`define TPU_REG_STATUS     8'h04
`define TPU_REG_LAYER_CFG  8'h14
`define TPU_REG_ARRAY_INFO 8'h18
`define TPU_REG_PERF_BUSY  8'h1C
`define TPU_REG_PERF_SKIP  8'h20
`define TPU_REG_PERF_CTRL  8'h2C

// Buffer windows
`define TPU_WIN_WGT 12'h100       // Weight words, index at addr[7:2]
`define TPU_WIN_ACT 12'h200       // Activations, index at addr[7:2]
`define TPU_WIN_OUT 12'h400       // Results, row addr[9:4], lane addr[3:2]

`endif

//--- source/tpu_pkg.sv
`default_nettype none

`include "tpu_params.svh"

package tpu_pkg;

  // Ternary weight code
  typedef logic [1:0] trit_t;

  localparam trit_t trit_pos = 2'b01;   // +1
  localparam trit_t trit_neg = 2'b11;   // -1
  // 00 is zero, 10 reserved and read as zero

  // One trit per lane
  typedef trit_t [`TPU_LANES-1:0] wgt_word_t;

  typedef logic signed [`TPU_ACT_BITS-1:0] act_t;
  typedef logic signed [`TPU_ACC_BITS-1:0] acc_t;

  // Row of lane accumulators, lane 0 in the low bits
  typedef acc_t [`TPU_LANES-1:0] acc_vec_t;

  // Shared index for all three buffers
  typedef logic [$clog2(`TPU_WGT_DEPTH)-1:0] buf_idx_t;

  // Layer rows and K
  typedef logic [15:0] dim_t;

  // Zero trits seen in one cycle, 0..lanes
  typedef logic [$clog2(`TPU_LANES+1)-1:0] skip_cnt_t;

endpackage

`default_nettype wire

//--- source/tpu_regs.sv
`default_nettype none

`include "tpu_params.svh"

module tpu_regs (
  input  logic                      clk,
  input  logic                      rst_n,
  // CPU bus
  input  logic                      cpu_sel,
  input  logic                      cpu_wen,
  input  logic                      cpu_ren,
  input  logic [`TPU_ADDR_BITS-1:0] cpu_addr,
  input  logic [`TPU_DATA_BITS-1:0] cpu_wdata,
  output logic [`TPU_DATA_BITS-1:0] cpu_rdata,
  output logic                      cpu_ready,
  // Core status
  input  logic                      busy,
  input  logic                      done,
  input  tpu_pkg::skip_cnt_t        skip_count,
  // Core control
  output logic                      start,
  output tpu_pkg::dim_t             rows,
  output tpu_pkg::dim_t             k,
  // Weight buffer write port
  output logic                      wgt_wr_en,
  output tpu_pkg::buf_idx_t         wgt_wr_idx,
  output tpu_pkg::wgt_word_t        wgt_wr_data,
  // Activation buffer write port
  output logic                      act_wr_en,
  output tpu_pkg::buf_idx_t         act_wr_idx,
  output tpu_pkg::act_t             act_wr_data,
  // Output buffer read port
  output logic                      out_rd_en,
  output tpu_pkg::buf_idx_t         out_rd_idx,
  input  tpu_pkg::acc_vec_t         out_rd_data,
  output logic                      irq
);
  import tpu_pkg::*;

  logic        wr_req;
  logic        rd_req;
  logic [7:0]  offset;
  logic        in_regs;
  logic        in_wgt;
  logic        in_act;
  logic        in_out;

  logic        ctrl_go;         // CTRL[0]
  logic        ctrl_go_d;
  logic        ctrl_irq_en;     // CTRL[8]
  logic        skip_clr;
  logic [31:0] layer_cfg;
  logic [15:0] skip_total;
  logic        perf_en;
  logic        perf_clr;
  logic [31:0] perf_busy;
  logic [31:0] perf_skip;
  logic        done_d;

  logic [`TPU_DATA_BITS-1:0] reg_rdata;
  logic [`TPU_DATA_BITS-1:0] rdata_q;
  logic        out_pend_q;      // Read data comes from output buffer
  logic [1:0]  out_lane_q;
  acc_t        out_lane_val;

  // ====================
  // Address decode
  // ====================
  assign wr_req  = cpu_sel & cpu_wen;
  assign rd_req  = cpu_sel & cpu_ren;
  assign offset  = cpu_addr[7:0];
  assign in_regs = (cpu_addr[11:8] == 4'h0);
  assign in_wgt  = (cpu_addr[11:8] == 4'(`TPU_WIN_WGT >> 8));
  assign in_act  = (cpu_addr[11:8] == 4'(`TPU_WIN_ACT >> 8));
  assign in_out  = (cpu_addr[11:10] == 2'(`TPU_WIN_OUT >> 10));

  // Buffer windows, loads locked out during a run
  assign wgt_wr_en   = wr_req & in_wgt & ~busy;
  assign wgt_wr_idx  = cpu_addr[7:2];
  assign wgt_wr_data = cpu_wdata[$bits(wgt_word_t)-1:0];   // Low byte only
  assign act_wr_en   = wr_req & in_act & ~busy;
  assign act_wr_idx  = cpu_addr[7:2];
  assign act_wr_data = cpu_wdata[`TPU_ACT_BITS-1:0];
  assign out_rd_en   = rd_req & in_out;
  assign out_rd_idx  = cpu_addr[9:4];

  // ====================
  // Control registers
  // ====================
  assign skip_clr = wr_req & in_regs & (offset == `TPU_REG_CTRL) & cpu_wdata[1];
  assign perf_clr = wr_req & in_regs & (offset == `TPU_REG_PERF_CTRL) & cpu_wdata[1];
  assign start    = ctrl_go & ~ctrl_go_d;   // Rising edge of CTRL[0]
  assign rows     = layer_cfg[15:0];
  assign k        = layer_cfg[31:16];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_go     <= 1'b0;
      ctrl_go_d   <= 1'b0;
      ctrl_irq_en <= 1'b0;
      layer_cfg   <= '0;
      perf_en     <= 1'b1;   // Counters run out of reset
    end else begin
      ctrl_go_d <= ctrl_go;
      if (ctrl_go && busy) begin
        ctrl_go <= 1'b0;   // Self-clear once the core has it
      end
      if (wr_req && in_regs) begin
        case (offset)
          `TPU_REG_CTRL: begin
            ctrl_go     <= cpu_wdata[0];
            ctrl_irq_en <= cpu_wdata[8];
          end
          `TPU_REG_LAYER_CFG: layer_cfg <= cpu_wdata;
          `TPU_REG_PERF_CTRL: perf_en   <= cpu_wdata[0];
          default: ;
        endcase
      end
    end
  end

  // ====================
  // Counters and irq
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      skip_total <= '0;
      perf_busy  <= '0;
      perf_skip  <= '0;
      done_d     <= 1'b0;
      irq        <= 1'b0;
    end else begin
      if (skip_clr) begin
        skip_total <= '0;
      end else begin
        skip_total <= skip_total + 16'(skip_count);   // Zero outside MAC slots
      end

      if (perf_clr) begin
        perf_busy <= '0;
        perf_skip <= '0;
      end else if (perf_en) begin
        if (start || busy) begin
          perf_busy <= perf_busy + 32'd1;   // Launch cycle through drain
        end
        perf_skip <= perf_skip + 32'(skip_count);
      end

      done_d <= done;
      if (ctrl_irq_en && done && !done_d) begin
        irq <= 1'b1;
      end else if (wr_req && in_regs && offset == `TPU_REG_STATUS) begin
        irq <= 1'b0;   // Any STATUS write acks
      end
    end
  end

  // ====================
  // Read path
  // ====================
  always_comb begin
    reg_rdata = '0;   // Unmapped reads
    if (in_regs) begin
      case (offset)
        `TPU_REG_CTRL:       reg_rdata = {23'b0, ctrl_irq_en, 7'b0, ctrl_go};
        `TPU_REG_STATUS:     reg_rdata = {skip_total, 7'b0, done, 6'b0, busy, 1'b0};
        `TPU_REG_LAYER_CFG:  reg_rdata = layer_cfg;
        `TPU_REG_ARRAY_INFO: reg_rdata = {`TPU_VERSION, 8'(`TPU_LANES), 8'(`TPU_ACC_BITS)};
        `TPU_REG_PERF_BUSY:  reg_rdata = perf_busy;
        `TPU_REG_PERF_SKIP:  reg_rdata = perf_skip;
        `TPU_REG_PERF_CTRL:  reg_rdata = {31'b0, perf_en};
        default:             reg_rdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cpu_ready  <= 1'b0;
      out_pend_q <= 1'b0;
    end else begin
      cpu_ready  <= wr_req | rd_req;   // Fixed one-cycle response
      out_pend_q <= out_rd_en;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_req) begin
      rdata_q    <= reg_rdata;
      out_lane_q <= cpu_addr[3:2];
    end
  end

  // Output buffer data lands with cpu_ready
  assign out_lane_val = out_rd_data[out_lane_q];
  assign cpu_rdata    = out_pend_q ?
                        {{(`TPU_DATA_BITS-`TPU_ACC_BITS){out_lane_val[`TPU_ACC_BITS-1]}},
                         out_lane_val} :
                        rdata_q;

  // Master issues a read or a write, never both
  a_one_cmd: assert property (
    @(posedge clk) disable iff (!rst_n) cpu_sel |-> !(cpu_wen && cpu_ren)
  ) else $error("cpu_wen and cpu_ren together");

endmodule

`default_nettype wire

//--- source/tpu_top.sv
`default_nettype none

`include "tpu_params.svh"

module tpu_top (
  input  logic                      clk,
  input  logic                      rst_n,
  // CPU bus
  input  logic                      cpu_sel,
  input  logic                      cpu_wen,
  input  logic                      cpu_ren,
  input  logic [`TPU_ADDR_BITS-1:0] cpu_addr,
  input  logic [`TPU_DATA_BITS-1:0] cpu_wdata,
  output logic [`TPU_DATA_BITS-1:0] cpu_rdata,
  output logic                      cpu_ready,
  output logic                      irq,
  output logic                      busy,
  output logic                      done
);
  import tpu_pkg::*;

  logic      start;
  dim_t      rows;
  dim_t      k;
  skip_cnt_t skip_count;

  logic      wgt_wr_en;
  buf_idx_t  wgt_wr_idx;
  wgt_word_t wgt_wr_data;
  logic      wgt_rd_en;
  buf_idx_t  wgt_rd_idx;
  wgt_word_t wgt_rd_data;   // Straight into MAC lanes

  logic      act_wr_en;
  buf_idx_t  act_wr_idx;
  act_t      act_wr_data;
  logic      act_rd_en;
  buf_idx_t  act_rd_idx;
  act_t      act_rd_data;

  logic      acc_en;
  logic      acc_load;
  acc_vec_t  sums;          // Output buffer write data

  logic      out_wr_en;
  buf_idx_t  out_wr_idx;
  logic      out_rd_en;
  buf_idx_t  out_rd_idx;
  acc_vec_t  out_rd_data;

  // ====================
  // Buffers
  // ====================
  tpu_buffer #(.entry_t(wgt_word_t), .depth(`TPU_WGT_DEPTH)) u_wgt_buf (
    .clk     (clk),
    .wr_en   (wgt_wr_en),
    .wr_idx  (wgt_wr_idx),
    .wr_data (wgt_wr_data),
    .rd_en   (wgt_rd_en),
    .rd_idx  (wgt_rd_idx),
    .rd_data (wgt_rd_data)
  );

  tpu_buffer #(.entry_t(act_t), .depth(`TPU_ACT_DEPTH)) u_act_buf (
    .clk     (clk),
    .wr_en   (act_wr_en),
    .wr_idx  (act_wr_idx),
    .wr_data (act_wr_data),
    .rd_en   (act_rd_en),
    .rd_idx  (act_rd_idx),
    .rd_data (act_rd_data)
  );

  tpu_buffer #(.entry_t(acc_vec_t), .depth(`TPU_OUT_DEPTH)) u_out_buf (
    .clk     (clk),
    .wr_en   (out_wr_en),
    .wr_idx  (out_wr_idx),
    .wr_data (sums),
    .rd_en   (out_rd_en),
    .rd_idx  (out_rd_idx),
    .rd_data (out_rd_data)
  );

  // ====================
  // Compute core
  // ====================
  layer_sequencer u_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .rows       (rows),
    .k          (k),
    .busy       (busy),
    .done       (done),
    .wgt_rd_en  (wgt_rd_en),
    .wgt_rd_idx (wgt_rd_idx),
    .act_rd_en  (act_rd_en),
    .act_rd_idx (act_rd_idx),
    .acc_en     (acc_en),
    .acc_load   (acc_load),
    .out_wr_en  (out_wr_en),
    .out_wr_idx (out_wr_idx)
  );

  ternary_mac_row u_mac (
    .clk        (clk),
    .rst_n      (rst_n),
    .acc_en     (acc_en),
    .acc_load   (acc_load),
    .weights    (wgt_rd_data),
    .act        (act_rd_data),
    .sums       (sums),
    .skip_count (skip_count)
  );

  // CPU side
  tpu_regs u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .cpu_sel     (cpu_sel),
    .cpu_wen     (cpu_wen),
    .cpu_ren     (cpu_ren),
    .cpu_addr    (cpu_addr),
    .cpu_wdata   (cpu_wdata),
    .cpu_rdata   (cpu_rdata),
    .cpu_ready   (cpu_ready),
    .busy        (busy),
    .done        (done),
    .skip_count  (skip_count),
    .start       (start),
    .rows        (rows),
    .k           (k),
    .wgt_wr_en   (wgt_wr_en),
    .wgt_wr_idx  (wgt_wr_idx),
    .wgt_wr_data (wgt_wr_data),
    .act_wr_en   (act_wr_en),
    .act_wr_idx  (act_wr_idx),
    .act_wr_data (act_wr_data),
    .out_rd_en   (out_rd_en),
    .out_rd_idx  (out_rd_idx),
    .out_rd_data (out_rd_data),
    .irq         (irq)
  );

endmodule

`default_nettype wire

//--- tests/tpu_checker.sv
`default_nettype none

`include "tpu_params.svh"

module tpu_checker (
  input  logic                      clk,
  input  logic                      rst_n,
  // Bus as seen by the DUT
  input  logic                      cpu_sel,
  input  logic                      cpu_wen,
  input  logic                      cpu_ren,
  input  logic [`TPU_ADDR_BITS-1:0] cpu_addr,
  input  logic [`TPU_DATA_BITS-1:0] cpu_rdata,
  input  logic                      cpu_ready,
  input  logic                      irq,
  input  logic                      busy,
  input  logic                      done,
  // Expectations from the trace
  input  logic [`TPU_DATA_BITS-1:0] exp_rdata,
  input  logic                      irq_chk,
  input  logic                      irq_exp,
  output int                        data_errs,
  output int                        irq_errs,
  output int                        proto_errs,
  output int                        checks
);

  logic                      armed;       // Out of reset
  logic                      req_q;       // Request taken last edge
  logic                      rd_q;
  logic [`TPU_ADDR_BITS-1:0] addr_q;
  logic [`TPU_DATA_BITS-1:0] exp_q;
  logic                      irq_chk_q;
  logic                      irq_exp_q;
  logic                      busy_q;      // Core status one edge back
  logic                      done_q;

  // ====================
  // Capture on the DUT sampling edge
  // ====================
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      armed     <= 1'b0;
      req_q     <= 1'b0;
      rd_q      <= 1'b0;
      addr_q    <= '0;
      exp_q     <= '0;
      irq_chk_q <= 1'b0;
      irq_exp_q <= 1'b0;
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      armed     <= 1'b1;
      req_q     <= cpu_sel & (cpu_wen | cpu_ren);
      rd_q      <= cpu_sel & cpu_ren;
      addr_q    <= cpu_addr;
      exp_q     <= exp_rdata;   // Held with the read request
      irq_chk_q <= irq_chk;
      irq_exp_q <= irq_exp;
      busy_q    <= busy;
      done_q    <= done;
    end
  end

  // ====================
  // Compare mid-cycle
  // ====================
  always @(negedge clk) begin
    if (!armed) begin
      data_errs  = 0;
      irq_errs   = 0;
      proto_errs = 0;
      checks     = 0;
    end else begin
      // Ready exactly one cycle after each request
      if (cpu_ready !== req_q) begin
        proto_errs++;
        $display("FAILED at time %0t: cpu_ready is %b, expected %b",
                 $time, cpu_ready, req_q);
      end
      // Busy falls in the cycle that done rises
      if (busy && done) begin
        proto_errs++;
        $display("FAILED at time %0t: busy and done are both high", $time);
      end
      if (done && !done_q && !busy_q) begin
        proto_errs++;
        $display("FAILED at time %0t: done rose without busy high before it", $time);
      end
      if (rd_q) begin
        checks++;
        if (cpu_rdata !== exp_q) begin
          data_errs++;
          $display("FAILED at time %0t: read of 0x%03h gave 0x%08h, expected 0x%08h",
                   $time, addr_q, cpu_rdata, exp_q);
        end
      end
      if (irq_chk_q) begin
        checks++;
        if (irq !== irq_exp_q) begin   // Level check only
          irq_errs++;
          $display("FAILED at time %0t: irq is %b, expected %b", $time, irq, irq_exp_q);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/tpu_tb.sv
`default_nettype none

`include "tpu_params.svh"

module tpu_tb;

  localparam int trace_depth  = 256;
  localparam int reset_cycles = 8;
  localparam int line_cycles  = 20;   // Budget per trace command

  logic                      clk;
  logic                      rst_n;
  logic                      cpu_sel;
  logic                      cpu_wen;
  logic                      cpu_ren;
  logic [`TPU_ADDR_BITS-1:0] cpu_addr;
  logic [`TPU_DATA_BITS-1:0] cpu_wdata;
  logic [`TPU_DATA_BITS-1:0] cpu_rdata;
  logic                      cpu_ready;
  logic                      irq;
  logic                      busy;
  logic                      done;

  logic [`TPU_DATA_BITS-1:0] exp_rdata;
  logic                      irq_chk;
  logic                      irq_exp;
  int                        data_errs;
  int                        irq_errs;
  int                        proto_errs;
  int                        checks;

  logic [47:0] trace_mem [trace_depth];   // Op, addr and data fields
  int          cycle_cnt = 0;
  int          cycle_limit = 0;
  int          done_rises;
  int          runs_seen = 0;
  int          bad_cmds = 0;
  logic        done_q;

  tpu_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cpu_sel   (cpu_sel),
    .cpu_wen   (cpu_wen),
    .cpu_ren   (cpu_ren),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .cpu_rdata (cpu_rdata),
    .cpu_ready (cpu_ready),
    .irq       (irq),
    .busy      (busy),
    .done      (done)
  );

  tpu_checker checker_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .cpu_sel    (cpu_sel),
    .cpu_wen    (cpu_wen),
    .cpu_ren    (cpu_ren),
    .cpu_addr   (cpu_addr),
    .cpu_rdata  (cpu_rdata),
    .cpu_ready  (cpu_ready),
    .irq        (irq),
    .busy       (busy),
    .done       (done),
    .exp_rdata  (exp_rdata),
    .irq_chk    (irq_chk),
    .irq_exp    (irq_exp),
    .data_errs  (data_errs),
    .irq_errs   (irq_errs),
    .proto_errs (proto_errs),
    .checks     (checks)
  );

  // ====================
  // Clock, timeout and done edges
  // ====================
  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // Rising edges of the sticky done
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_q     <= 1'b0;
      done_rises <= 0;
    end else begin
      done_q <= done;
      if (done && !done_q) begin
        done_rises <= done_rises + 1;
      end
    end
  end

  // ====================
  // Bus tasks
  // ====================
  task automatic idle_gap();
    int gap;
    gap = int'($urandom % 4);
    repeat (gap) @(negedge clk);
  endtask

  task automatic bus_write(input logic [11:0] addr, input logic [31:0] data);
    @(negedge clk);
    cpu_sel   = 1'b1;
    cpu_wen   = 1'b1;
    cpu_addr  = addr;
    cpu_wdata = data;
    @(negedge clk);   // Bus goes quiet in the ready cycle
    cpu_sel   = 1'b0;
    cpu_wen   = 1'b0;
  endtask

  task automatic bus_read(input logic [11:0] addr, input logic [31:0] expected);
    @(negedge clk);
    cpu_sel   = 1'b1;
    cpu_ren   = 1'b1;
    cpu_addr  = addr;
    exp_rdata = expected;   // Latched by the checker with the request
    @(negedge clk);
    cpu_sel   = 1'b0;
    cpu_ren   = 1'b0;
  endtask

  task automatic expect_irq(input logic level);
    @(negedge clk);
    irq_chk = 1'b1;
    irq_exp = level;
    @(negedge clk);
    irq_chk = 1'b0;
  endtask

  task automatic wait_for_done();
    while (done_rises <= runs_seen) begin
      @(negedge clk);
    end
    runs_seen++;
  endtask

  // ====================
  // Trace player
  // ====================
  initial begin
    int          n_cmds;
    int          run_cycles;
    logic [15:0] rows_cfg;
    logic [15:0] k_cfg;
    logic [3:0]  op;
    logic [11:0] addr;
    logic [31:0] data;

    void'($urandom(78247));
    rst_n     = 1'b0;
    cpu_sel   = 1'b0;
    cpu_wen   = 1'b0;
    cpu_ren   = 1'b0;
    cpu_addr  = '0;
    cpu_wdata = '0;
    exp_rdata = '0;
    irq_chk   = 1'b0;
    irq_exp   = 1'b0;

    for (int i = 0; i < trace_depth; i++) begin
      trace_mem[i] = '0;   // Op 0 marks the end
    end
    $readmemh("tests/tpu_trace.txt", trace_mem);

    // Size the timeout from the trace itself
    n_cmds     = 0;
    run_cycles = 0;
    rows_cfg   = '0;
    k_cfg      = '0;
    while (n_cmds < trace_depth && trace_mem[n_cmds][47:44] != 4'h0) begin
      op   = trace_mem[n_cmds][47:44];
      addr = trace_mem[n_cmds][43:32];
      data = trace_mem[n_cmds][31:0];
      if (op == 4'h1 && addr == 12'(`TPU_REG_LAYER_CFG)) begin
        rows_cfg = data[15:0];
        k_cfg    = data[31:16];
      end
      if (op == 4'h1 && addr == 12'(`TPU_REG_CTRL) && data[0]) begin
        run_cycles = run_cycles + int'(rows_cfg) * int'(k_cfg) + 3;
      end
      n_cmds++;
    end
    cycle_limit = reset_cycles + line_cycles * n_cmds + run_cycles;

    repeat (reset_cycles) @(negedge clk);
    rst_n = 1'b1;

    for (int idx = 0; idx < n_cmds; idx++) begin
      op   = trace_mem[idx][47:44];
      addr = trace_mem[idx][43:32];
      data = trace_mem[idx][31:0];
      idle_gap();
      case (op)
        4'h1: bus_write(addr, data);
        4'h2: bus_read(addr, data);
        4'h3: wait_for_done();
        4'h4: expect_irq(data[0]);
        default: begin
          bad_cmds++;
          $display("Trace entry %0d has an unknown command code %0h", idx, op);
        end
      endcase
    end
    repeat (2) @(negedge clk);   // Let the last compare land

    $display("Errors: data %0d, irq %0d, protocol %0d, trace %0d, after %0d checks",
             data_errs, irq_errs, proto_errs, bad_cmds, checks);
    if (data_errs + irq_errs + proto_errs + bad_cmds == 0 && checks > 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/tpu_trace.txt
// One 48-bit hex word per line: op[47:44] addr[43:32] data[31:0]
// op 1 write, 2 read and expect data, 3 wait for done, 4 expect irq level, 0 end
// Reset values: CTRL, STATUS, PERF_CTRL, ARRAY_INFO, LAYER_CFG, unmapped
200000000000
200400000000
202C00000001
201800020414
201400000000
203000000000
// Layer R=3 K=4
101400040003
201400040003
// Weights, upper bits ignored; zero or reserved trits per word 1 2 1 1
1100ABCDEF4D
11040000001B
1108000000F4
110C00000065
// Activations rows 0..2
12000000000A
1204FFFFFFEC
12080000001E
120C00000005
12100000007F
121400000080
121800000040
121C000000FF
122000000003
122400000007
1228FFFFFFF7
122C00000064
// Run 1 with irq enabled
400000000000
100000000101
300000000000
400000000001
2004000F0100
201C0000000F
20200000000F
200000000100
// Outputs row 0: 35 25 -50 -15
240000000023
240400000019
2408FFFFFFCE
240CFFFFFFF1
// Row 1: 254 -64 -192 62
2410000000FE
2414FFFFFFC0
2418FFFFFF40
241C0000003E
// Row 2: 96 88 16 112
242000000060
242400000058
242800000010
242C00000070
// Ack irq, clear status skip count only
100400000000
400000000000
100000000102
200400000100
20200000000F
200000000100
// Clear perf counters, keep them enabled
102C00000003
201C00000000
202000000000
202C00000001
// Run 2, new row 1 activations, irq disabled
1210FFFFFFFB
121400000002
1218FFFFFFFD
121C00000008
100000000001
300000000000
400000000000
2004000F0100
201C0000000F
20200000000F
// Row 1: 1 10 5 6, row 0 unchanged
241000000001
24140000000A
241800000005
241C00000006
240000000023
000000000000

//--- tritone_tpu.f
+incdir+source
source/tpu_pkg.sv
source/tpu_buffer.sv
source/ternary_mac_row.sv
source/layer_sequencer.sv
source/tpu_regs.sv
source/tpu_top.sv
tests/tpu_checker.sv
tests/tpu_tb.sv
